//--- flist.f
mipsExPkg.sv
pipeStage.sv
aluCore.sv
mulAccum.sv
exStage.sv
exStage_checker.sv
exStage_tb.sv

//--- run.sh
#!/bin/sh
# builds the exStage testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module exStage_tb -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/VexStage_tb)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOut" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- exStage_tb.sv
// Testbench for the MIPS32 execute stage
// directed and random op streams checked against a software model
`timescale 1ns/1ns
`default_nettype none

module exStage_tb;

    localparam logic [31:0] seedInit = 32'he18681de;

    logic                               clk;
    logic                               rst;
    logic                               inValid;
    mipsExPkg::aluOpT                   inOp;
    logic [mipsExPkg::dataW-1:0]        inOpr1;
    logic [mipsExPkg::dataW-1:0]        inOpr2;
    logic                               outReady;
    logic                               inReady;
    logic                               outValid;
    mipsExPkg::aluOpT                   outOp;
    logic [mipsExPkg::dataW-1:0]        outResult;

    logic [31:0]                        opSeed = seedInit;
    logic [31:0]                        stallSeed = ~seedInit;  // separate stream for stalls
    logic                               randStall = 1'b0;
    logic [mipsExPkg::dwordW-1:0]       refHilo = '0;
    logic [mipsExPkg::dataW-1:0]        expRes[$];
    mipsExPkg::aluOpT                   expOp[$];
    int                                 errors = 0;
    int                                 testErrors = 0;
    int                                 issued = 0;
    int                                 checked = 0;

    exStage dut (
        .clk(clk), .rst(rst), .inValid(inValid), .inOp(inOp), .inOpr1(inOpr1),
        .inOpr2(inOpr2), .outReady(outReady), .inReady(inReady), .outValid(outValid),
        .outOp(outOp), .outResult(outResult)
    );

    function automatic logic [31:0] lcgStep(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] randWord();
        opSeed = lcgStep(opSeed);
        return opSeed;
    endfunction

    function automatic logic [31:0] leadCount(input logic [31:0] w, input logic v);
        logic [31:0] n;
        logic        run;
        n = 0;
        run = 1'b1;
        for (int i = 31; i >= 0; i--) begin
            if (run && w[i] == v) n = n + 1;
            else run = 1'b0;
        end
        return n;
    endfunction

    // MIPS32 semantics, HI/LO kept in program order
    function automatic logic [31:0] refExec(input mipsExPkg::aluOpT op,
                                            input logic [31:0] a, input logic [31:0] b);
        logic signed [63:0] sProd;
        logic [63:0]        uProd;
        logic [31:0]        r;
        sProd = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        uProd = {32'b0, a} * {32'b0, b};
        r = 32'b0;  // hilo writers return zero
        case (op)
            mipsExPkg::aluAdd, mipsExPkg::aluAddu: r = a + b;
            mipsExPkg::aluSub, mipsExPkg::aluSubu: r = a - b;
            mipsExPkg::aluAnd:   r = a & b;
            mipsExPkg::aluOr:    r = a | b;
            mipsExPkg::aluXor:   r = a ^ b;
            mipsExPkg::aluNor:   r = ~(a | b);
            mipsExPkg::aluSll:   r = b << a[4:0];
            mipsExPkg::aluSrl:   r = b >> a[4:0];
            mipsExPkg::aluSra:   r = $signed(b) >>> a[4:0];
            mipsExPkg::aluSlt:   r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            mipsExPkg::aluSltu:  r = (a < b) ? 32'd1 : 32'd0;
            mipsExPkg::aluMov:   r = a;
            mipsExPkg::aluMthi: begin
                r = a;
                refHilo[63:32] = a;
            end
            mipsExPkg::aluMtlo: begin
                r = a;
                refHilo[31:0] = a;
            end
            mipsExPkg::aluMfhi:  r = refHilo[63:32];
            mipsExPkg::aluMflo:  r = refHilo[31:0];
            mipsExPkg::aluClo:   r = leadCount(a, 1'b1);
            mipsExPkg::aluClz:   r = leadCount(a, 1'b0);
            mipsExPkg::aluMul:   r = sProd[31:0];
            mipsExPkg::aluMult:  refHilo = sProd;
            mipsExPkg::aluMultu: refHilo = uProd;
            mipsExPkg::aluMadd:  refHilo = refHilo + sProd;
            mipsExPkg::aluMaddu: refHilo = refHilo + uProd;
            mipsExPkg::aluMsub:  refHilo = refHilo - sProd;
            mipsExPkg::aluMsubu: refHilo = refHilo - uProd;
            default:             r = 32'b0;
        endcase
        return r;
    endfunction

    task automatic checkWord(input string name, input logic [mipsExPkg::dataW-1:0] got,
                             input logic [mipsExPkg::dataW-1:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
            testErrors++;
        end
    endtask

    task automatic checkOp(input string name, input mipsExPkg::aluOpT got,
                           input mipsExPkg::aluOpT exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %s, expected %s", $time, name, got.name(),
                     exp.name());
            errors++;
            testErrors++;
        end
    endtask

    task automatic checkResult(input mipsExPkg::aluOpT op, input logic [31:0] res);
        checkOp("outOp", outOp, op);
        checkWord("outResult", outResult, res);
        checked++;
    endtask

    // holds the op until accepted, model runs at acceptance
    task automatic issue(input mipsExPkg::aluOpT op, input logic [31:0] a,
                         input logic [31:0] b);
        inValid <= 1'b1;
        inOp <= op;
        inOpr1 <= a;
        inOpr2 <= b;
        do @(negedge clk); while (!inReady);
        expOp.push_back(op);
        expRes.push_back(refExec(op, a, b));
        issued++;
        @(posedge clk);
    endtask

    task automatic issueRandom(input mipsExPkg::aluOpT op);
        logic [31:0] a;
        logic [31:0] b;
        a = randWord();
        b = randWord();
        issue(op, a, b);
    endtask

    task automatic drainAndReport(input string name);
        inValid <= 1'b0;
        while (expRes.size() != 0) @(posedge clk);
        $display("%s finished with %0d errors", name, testErrors);
        testErrors = 0;
    endtask

    task automatic mulSequence(input logic [31:0] a, input logic [31:0] b);
        issue(mipsExPkg::aluMult, a, b);
        issue(mipsExPkg::aluMfhi, 32'b0, 32'b0);
        issue(mipsExPkg::aluMflo, 32'b0, 32'b0);
        issue(mipsExPkg::aluMultu, a, b);
        issue(mipsExPkg::aluMfhi, 32'b0, 32'b0);
        issue(mipsExPkg::aluMflo, 32'b0, 32'b0);
        issue(mipsExPkg::aluMul, a, b);
    endtask

    task automatic runMultiplies();
        logic [31:0] vals [0:5];
        vals[0] = 32'h0000_0000;
        vals[1] = 32'h0000_0001;
        vals[2] = 32'hffff_ffff;
        vals[3] = 32'h8000_0000;
        vals[4] = 32'h7fff_ffff;
        vals[5] = 32'h0001_ffff;  // crosses the 16-bit split
        for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < 6; j++) mulSequence(vals[i], vals[j]);
        end
        for (int k = 0; k < 20; k++) mulSequence(randWord(), randWord());
        drainAndReport("multiplies");
    endtask

    task automatic runAccumulate();
        mipsExPkg::aluOpT accOps [0:5];
        accOps[0] = mipsExPkg::aluMthi;
        accOps[1] = mipsExPkg::aluMtlo;
        accOps[2] = mipsExPkg::aluMadd;
        accOps[3] = mipsExPkg::aluMsubu;
        accOps[4] = mipsExPkg::aluMaddu;
        accOps[5] = mipsExPkg::aluMsub;
        for (int i = 0; i < 60; i++) begin
            issueRandom((i < 6) ? accOps[i] : accOps[randWord() % 6]);
            issue(mipsExPkg::aluMfhi, 32'b0, 32'b0);
            issue(mipsExPkg::aluMflo, 32'b0, 32'b0);
        end
        drainAndReport("accumulate with forwarding");
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // outReady stays high unless a stall pattern is requested
    initial begin
        outReady = 1'b1;
        forever begin
            @(posedge clk);
            stallSeed = lcgStep(stallSeed);
            outReady <= randStall ? (stallSeed[20] | stallSeed[9]) : 1'b1;
        end
    end

    // values are stable at the falling edge before the transfer edge
    initial begin
        forever begin
            @(negedge clk);
            if (!rst && outValid && outReady) begin
                if (expRes.size() == 0) begin
                    $display("Error at %0t ns: output transfer with no operation pending",
                             $time);
                    errors++;
                    testErrors++;
                end else begin
                    checkResult(expOp.pop_front(), expRes.pop_front());
                end
            end
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles <= 200 * issued + 1000) begin
            @(posedge clk);
            cycles++;
        end
        $display("watchdog expired after %0d cycles with %0d operations issued", cycles,
                 issued);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        rst = 1'b1;
        inValid = 1'b0;
        inOp = mipsExPkg::aluNop;
        inOpr1 = '0;
        inOpr2 = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < 300; i++) issueRandom(mipsExPkg::aluOpT'(5'(randWord() % 14)));
        issueRandom(mipsExPkg::aluNop);
        drainAndReport("arithmetic, logic, shifts and compares");

        issue(mipsExPkg::aluClz, 32'h0, 32'h0);
        issue(mipsExPkg::aluClo, 32'h0, 32'h0);
        issue(mipsExPkg::aluClz, 32'hffff_ffff, 32'h0);
        issue(mipsExPkg::aluClo, 32'hffff_ffff, 32'h0);
        for (int i = 0; i < 32; i++) begin
            issue(mipsExPkg::aluClz, 32'h1 << i, 32'h0);
            issue(mipsExPkg::aluClo, ~(32'h1 << i), 32'h0);
        end
        for (int i = 0; i < 20; i++) begin
            issueRandom(mipsExPkg::aluClz);
            issueRandom(mipsExPkg::aluClo);
        end
        drainAndReport("CLO and CLZ");

        runMultiplies();
        runAccumulate();

        randStall <= 1'b1;
        for (int i = 0; i < 200; i++) issueRandom(mipsExPkg::aluOpT'(5'(randWord() % 28)));
        issue(mipsExPkg::aluMfhi, 32'b0, 32'b0);
        issue(mipsExPkg::aluMflo, 32'b0, 32'b0);
        drainAndReport("back-pressure");
        randStall <= 1'b0;

        $display("%0d operations issued, %0d results checked, %0d errors", issued, checked,
                 errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- exStage_checker.sv
// Handshake and reset checks for the execute stage
// attached to exStage through bind
`timescale 1ns/1ns
`default_nettype none

module exStage_checker (
    input wire logic                             clk,
    input wire logic                             rst,
    input wire logic                             inReady,
    input wire logic                             outValid,
    input wire logic                             outReady,
    input wire mipsExPkg::aluOpT                 outOp,
    input wire logic [mipsExPkg::dataW-1:0]      outResult
);

    assert property (@(posedge clk) rst |=> !outValid)
        else $error("outValid is high in the cycle after reset");

    // stalled output must hold
    assert property (@(posedge clk) disable iff (rst)
        outValid && !outReady |=> outValid && $stable(outResult) && $stable(outOp))
        else $error("output changed while stalled by outReady");

    assert property (@(posedge clk) disable iff (rst) outReady |-> inReady)
        else $error("inReady is low although outReady is high");

endmodule

bind exStage exStage_checker uChecker (
    .clk(clk), .rst(rst), .inReady(inReady), .outValid(outValid),
    .outReady(outReady), .outOp(outOp), .outResult(outResult)
);

`default_nettype wire

//--- exStage.sv
// MIPS32 integer execute stage, two-deep pipeline
// aluCore feeds stage 1, mulAccum finishes multiplies into stage 2
`timescale 1ns/1ns
`default_nettype none

module exStage (
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire logic                             inValid,
    input  wire mipsExPkg::aluOpT                 inOp,
    input  wire logic [mipsExPkg::dataW-1:0]      inOpr1,
    input  wire logic [mipsExPkg::dataW-1:0]      inOpr2,
    input  wire logic                             outReady,

    output logic                                  inReady,
    output logic                                  outValid,
    output mipsExPkg::aluOpT                      outOp,
    output logic [mipsExPkg::dataW-1:0]           outResult
);

    logic [mipsExPkg::dataW-1:0]    aluRes;
    logic [mipsExPkg::dwordW-1:0]   mulLo;
    logic [mipsExPkg::dwordW-1:0]   mulHi;
    logic                           mulSign;

    logic [mipsExPkg::dwordW-1:0]   hilo;
    logic                           pendValid;
    logic [mipsExPkg::dwordW-1:0]   pendHilo;
    logic [mipsExPkg::dataW-1:0]    mulResult;

    mipsExPkg::mulStageT            s1In;
    mipsExPkg::mulStageT            s1Out;
    logic                           s1Valid;
    mipsExPkg::resStageT            s2In;
    mipsExPkg::resStageT            s2Out;
    logic                           s2Ready;
    logic                           advance;

    aluCore uAlu (
        .op(inOp), .opr1(inOpr1), .opr2(inOpr2),
        .hilo(hilo), .pendValid(pendValid), .pendHilo(pendHilo),
        .aluRes(aluRes), .mulLo(mulLo), .mulHi(mulHi), .mulSign(mulSign)
    );

    assign s1In = '{op: inOp, aluRes: aluRes, opr1: inOpr1,
                    mulLo: mulLo, mulHi: mulHi, mulSign: mulSign};

    pipeStage #(.payloadT(mipsExPkg::mulStageT)) mulStage (
        .clk(clk), .rst(rst),
        .upValid(inValid), .upData(s1In), .upReady(inReady),
        .downValid(s1Valid), .downData(s1Out), .downReady(s2Ready)
    );

    assign advance = s1Valid & s2Ready;  // stage 1 -> stage 2 handoff

    mulAccum uMulAccum (
        .clk(clk), .rst(rst), .valid(s1Valid), .advance(advance),
        .op(s1Out.op), .opr1(s1Out.opr1), .aluRes(s1Out.aluRes),
        .mulLo(s1Out.mulLo), .mulHi(s1Out.mulHi), .mulSign(s1Out.mulSign),
        .result(mulResult), .hilo(hilo), .pendValid(pendValid), .pendHilo(pendHilo)
    );

    assign s2In = '{op: s1Out.op, result: mulResult};

    pipeStage #(.payloadT(mipsExPkg::resStageT)) resStage (
        .clk(clk), .rst(rst),
        .upValid(s1Valid), .upData(s2In), .upReady(s2Ready),
        .downValid(outValid), .downData(s2Out), .downReady(outReady)
    );

    assign outOp     = s2Out.op;
    assign outResult = s2Out.result;

endmodule

`default_nettype wire

//--- mulAccum.sv
// Second multiply stage and HI/LO owner
// combines partial products, applies sign, accumulates into HI/LO
`timescale 1ns/1ns
`default_nettype none

module mulAccum (
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire logic                             valid,
    input  wire logic                             advance,
    input  wire mipsExPkg::aluOpT                 op,
    input  wire logic [mipsExPkg::dataW-1:0]      opr1,
    input  wire logic [mipsExPkg::dataW-1:0]      aluRes,
    input  wire logic [mipsExPkg::dwordW-1:0]     mulLo,
    input  wire logic [mipsExPkg::dwordW-1:0]     mulHi,
    input  wire logic                             mulSign,

    output logic [mipsExPkg::dataW-1:0]           result,
    output logic [mipsExPkg::dwordW-1:0]          hilo,
    output logic                                  pendValid,
    output logic [mipsExPkg::dwordW-1:0]          pendHilo
);

    logic [mipsExPkg::dwordW-1:0]   mulMag;
    logic [mipsExPkg::dwordW-1:0]   product;
    logic                           writesHilo;

    // cross terms sit 16 bits up
    assign mulMag = {32'b0, mulLo[31:0]}
                  + {16'b0, mulLo[63:32], 16'b0}
                  + {16'b0, mulHi[31:0], 16'b0}
                  + {mulHi[63:32], 32'b0};

    assign product = mulSign ? (~mulMag + 64'd1) : mulMag;

    always_comb begin
        writesHilo = 1'b1;
        case (op)
            mipsExPkg::aluMult,
            mipsExPkg::aluMultu: pendHilo = product;
            mipsExPkg::aluMadd,
            mipsExPkg::aluMaddu: pendHilo = hilo + product;
            mipsExPkg::aluMsub,
            mipsExPkg::aluMsubu: pendHilo = hilo - product;
            mipsExPkg::aluMthi:  pendHilo = {opr1, hilo[31:0]};
            mipsExPkg::aluMtlo:  pendHilo = {hilo[63:32], opr1};
            default: begin
                pendHilo   = hilo;
                writesHilo = 1'b0;
            end
        endcase
    end

    assign pendValid = valid & writesHilo;  // forward to aluCore

    // MUL returns low word, HI/LO untouched
    assign result = (op == mipsExPkg::aluMul) ? product[31:0] : aluRes;

    // only on a real handoff, so a stall never double-accumulates
    always_ff @(posedge clk) begin
        if (rst) begin
            hilo <= '0;
        end else if (advance && pendValid) begin
            hilo <= pendHilo;
        end
    end

endmodule

`default_nettype wire

//--- aluCore.sv
// Integer ALU of the MIPS32 execute stage
// single-cycle ops, CLO/CLZ, HI/LO reads with forwarding,
// and magnitude partial products for the multiply path
`timescale 1ns/1ns
`default_nettype none

module aluCore (
    input  wire mipsExPkg::aluOpT                 op,
    input  wire logic [mipsExPkg::dataW-1:0]      opr1,
    input  wire logic [mipsExPkg::dataW-1:0]      opr2,

    input  wire logic [mipsExPkg::dwordW-1:0]     hilo,
    input  wire logic                             pendValid,
    input  wire logic [mipsExPkg::dwordW-1:0]     pendHilo,

    output logic [mipsExPkg::dataW-1:0]           aluRes,
    output logic [mipsExPkg::dwordW-1:0]          mulLo,
    output logic [mipsExPkg::dwordW-1:0]          mulHi,
    output logic                                  mulSign
);

    logic                               opr1Neg;
    logic                               opr2Neg;
    logic [mipsExPkg::dwordW-1:0]       hiloFwd;

    logic [mipsExPkg::dataW-1:0]        clzOpr;
    logic [mipsExPkg::dataW-1:0]        clzRes;
    logic                               clzUpper;
    logic                               clzByte;
    logic                               clzNib;
    logic [15:0]                        part1;
    logic [7:0]                         part2;
    logic [3:0]                         part3;
    logic [1:0]                         clzLow;

    logic [mipsExPkg::dataW-1:0]        mopr1;
    logic [mipsExPkg::dataW-1:0]        mopr2;

    assign opr1Neg = opr1[31];
    assign opr2Neg = opr2[31];

    // in-flight HI/LO write wins over the register
    assign hiloFwd = pendValid ? pendHilo : hilo;

    // CLO counts zeros of the inverted word
    always_comb begin
        case (op)
            mipsExPkg::aluClo: clzOpr = ~opr1;
            mipsExPkg::aluClz: clzOpr = opr1;
            default:           clzOpr = '0;
        endcase
    end

    assign clzUpper = (clzOpr[31:16] == 16'b0);
    assign part1    = clzUpper ? clzOpr[15:0] : clzOpr[31:16];
    assign clzByte  = (part1[15:8] == 8'b0);
    assign part2    = clzByte ? part1[7:0] : part1[15:8];
    assign clzNib   = (part2[7:4] == 4'b0);
    assign part3    = clzNib ? part2[3:0] : part2[7:4];

    always_comb begin
        casez (part3)
            4'b0001: clzLow = 2'b11;
            4'b001?: clzLow = 2'b10;
            4'b01??: clzLow = 2'b01;
            default: clzLow = 2'b00;
        endcase
    end

    assign clzRes = (clzOpr == '0) ? 32'd32
                                   : {27'b0, clzUpper, clzByte, clzNib, clzLow};

    // operand magnitudes, sign recorded separately
    always_comb begin
        case (op)
            mipsExPkg::aluMul, mipsExPkg::aluMult,
            mipsExPkg::aluMadd, mipsExPkg::aluMsub: begin
                mopr1   = opr1Neg ? (~opr1 + 32'd1) : opr1;
                mopr2   = opr2Neg ? (~opr2 + 32'd1) : opr2;
                mulSign = opr1Neg ^ opr2Neg;
            end
            mipsExPkg::aluMultu, mipsExPkg::aluMaddu, mipsExPkg::aluMsubu: begin
                mopr1   = opr1;
                mopr2   = opr2;
                mulSign = 1'b0;
            end
            default: begin
                mopr1   = '0;  // keeps partials at zero
                mopr2   = '0;
                mulSign = 1'b0;
            end
        endcase
    end

    assign mulLo[31:0]  = mopr1[15:0]  * mopr2[15:0];
    assign mulLo[63:32] = mopr1[31:16] * mopr2[15:0];
    assign mulHi[31:0]  = mopr1[15:0]  * mopr2[31:16];
    assign mulHi[63:32] = mopr1[31:16] * mopr2[31:16];

    always_comb begin
        case (op)
            mipsExPkg::aluSll:  aluRes = opr2 << opr1[4:0];
            mipsExPkg::aluSrl:  aluRes = opr2 >> opr1[4:0];
            mipsExPkg::aluSra:  aluRes = $signed(opr2) >>> opr1[4:0];
            mipsExPkg::aluAdd,
            mipsExPkg::aluAddu: aluRes = opr1 + opr2;  // no overflow trap
            mipsExPkg::aluSub,
            mipsExPkg::aluSubu: aluRes = opr1 - opr2;
            mipsExPkg::aluAnd:  aluRes = opr1 & opr2;
            mipsExPkg::aluOr:   aluRes = opr1 | opr2;
            mipsExPkg::aluXor:  aluRes = opr1 ^ opr2;
            mipsExPkg::aluNor:  aluRes = ~(opr1 | opr2);
            mipsExPkg::aluSlt:  aluRes = {31'b0, $signed(opr1) < $signed(opr2)};
            mipsExPkg::aluSltu: aluRes = {31'b0, opr1 < opr2};
            mipsExPkg::aluMov,
            mipsExPkg::aluMthi,
            mipsExPkg::aluMtlo: aluRes = opr1;
            mipsExPkg::aluMfhi: aluRes = hiloFwd[63:32];
            mipsExPkg::aluMflo: aluRes = hiloFwd[31:0];
            mipsExPkg::aluClo,
            mipsExPkg::aluClz:  aluRes = clzRes;
            default:            aluRes = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- pipeStage.sv
// One-entry valid/ready register slice
// payload type is a parameter, loads on upstream transfer
`timescale 1ns/1ns
`default_nettype none

module pipeStage #(
    parameter type payloadT = logic
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       upValid,
    input  wire payloadT    upData,
    input  wire logic       downReady,

    output logic            upReady,
    output logic            downValid,
    output payloadT         downData
);

    // accept when empty or draining this cycle
    assign upReady = ~downValid | downReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            downValid <= 1'b0;
        end else if (upReady) begin
            downValid <= upValid;  // bubble if nothing arrives
        end
    end

    always_ff @(posedge clk) begin
        if (upValid && upReady) begin
            downData <= upData;
        end
    end

endmodule

`default_nettype wire

//--- mipsExPkg.sv
// MIPS32 execute stage shared definitions
// opcode encoding, data widths and the two pipeline payloads
`default_nettype none

package mipsExPkg;

    localparam int dataW  = 32;  // data word
    localparam int dwordW = 64;  // product and HI/LO pair

    // ALU opcodes as decoded upstream
    typedef enum logic [4:0] {
        aluAdd,   aluAddu,  aluSub,   aluSubu,
        aluAnd,   aluOr,    aluXor,   aluNor,
        aluSll,   aluSrl,   aluSra,
        aluSlt,   aluSltu,
        aluMov,   aluMthi,  aluMtlo,  aluMfhi,  aluMflo,
        aluClo,   aluClz,
        aluMul,   aluMult,  aluMultu,
        aluMadd,  aluMaddu, aluMsub,  aluMsubu,
        aluNop
    } aluOpT;

    // stage 1 payload, held between ALU and multiply combine
    typedef struct packed {
        aluOpT              op;
        logic [dataW-1:0]   aluRes;   // single-cycle result
        logic [dataW-1:0]   opr1;     // source for MTHI/MTLO
        logic [dwordW-1:0]  mulLo;    // {ah*bl, al*bl}
        logic [dwordW-1:0]  mulHi;    // {ah*bh, al*bh}
        logic               mulSign;  // product negative
    } mulStageT;

    // stage 2 payload, drives the output port
    typedef struct packed {
        aluOpT              op;
        logic [dataW-1:0]   result;
    } resStageT;

endpackage

`default_nettype wire
